// ==== logic/lsu_pkg.sv ====
/*
 * Load/store unit shared definitions.
 * Data, address and strobe types, data memory geometry and the
 * state encodings of the LSU control and the data memory.
 */

package lsu_pkg;

    // Data path types
    // ------------------------------

    typedef logic [31:0] word_t;    // One data word
    typedef logic [31:0] addr_t;    // Byte address
    typedef logic [3:0]  strb_t;    // One write strobe per byte lane
    typedef logic [1:0]  boff_t;    // Byte offset inside a word

    // Data memory geometry
    // ------------------------------

    localparam int DMEM_WORDS = 1024;   // Depth in words

    // First byte address that answers with a bus error
    localparam addr_t DMEM_ERR_BASE = addr_t'(DMEM_WORDS * 4);

    // State encodings
    // ------------------------------

    // LSU completion tracking
    typedef enum logic {
        LSU_IDLE,                   // No finished access pending
        LSU_HELD                    // Finished, waiting for pipe_prog
    } lsu_state_t;

    // Data memory access sequencing
    typedef enum logic {
        MEM_IDLE,                   // First cycle of an access or no access
        MEM_WAIT                    // Counting down wait states
    } mem_state_t;

endpackage

// ==== logic/lsu_ctrl.sv ====
/*
 * LSU control block.
 * Tracks completion of the current access until the pipeline takes it,
 * flags misaligned requests and drives the memory enables.
 */

`timescale 1ns/1ps

module lsu_ctrl (
    input  logic          g_clk,        // Global clock
    input  logic          g_resetn,     // Synchronous reset, active low
    input  logic          lsu_valid,    // Request present
    input  logic          lsu_store,    // Store request
    input  logic          lsu_byte,     // Byte width
    input  logic          lsu_half,     // Halfword width
    input  logic          lsu_word,     // Word width
    input  logic          pipe_prog,    // Pipeline takes the result
    input  lsu_pkg::boff_t lsu_boff,    // Byte offset of the request
    input  logic          dmem_stall,   // Memory not done yet
    input  logic          dmem_error,   // Memory bus error
    output logic          lsu_ready,    // Access complete
    output logic          lsu_a_error,  // Misaligned address
    output logic          lsu_b_error,  // Bus error on completion
    output logic          dmem_cen,     // Memory chip enable
    output logic          dmem_wen      // Memory write enable
);

    lsu_pkg::lsu_state_t lsu_state;
    lsu_pkg::lsu_state_t n_lsu_state;

    logic width_ok;                     // Some width bit is set
    logic txn_done;                     // Bus transfer completes this cycle

    // Request decode
    // ------------------------------

    assign width_ok = lsu_byte || lsu_half || lsu_word;

    // Halfword at odd offset, word at any nonzero offset
    assign lsu_a_error = lsu_valid &&
                         ((lsu_half && lsu_boff[0]) ||
                          (lsu_word && (lsu_boff != 2'b00)));

    // Memory bus
    // ------------------------------

    assign dmem_cen = lsu_valid && width_ok && !lsu_a_error &&
                      (lsu_state == lsu_pkg::LSU_IDLE);    // No repeat while held
    assign dmem_wen = lsu_store;

    assign txn_done = dmem_cen && !dmem_stall;

    // Completion tracking
    // ------------------------------

    always_comb begin
        n_lsu_state = lsu_state;
        case (lsu_state)
            lsu_pkg::LSU_IDLE: begin
                if (txn_done && !pipe_prog) begin
                    n_lsu_state = lsu_pkg::LSU_HELD;        // Result not taken yet
                end
            end
            lsu_pkg::LSU_HELD: begin
                if (pipe_prog) begin
                    n_lsu_state = lsu_pkg::LSU_IDLE;
                end
            end
            default: n_lsu_state = lsu_pkg::LSU_IDLE;
        endcase
    end

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            lsu_state <= lsu_pkg::LSU_IDLE;
        end else begin
            lsu_state <= n_lsu_state;
        end
    end

    // Execute stage outputs
    // ------------------------------

    assign lsu_ready   = txn_done || (lsu_state == lsu_pkg::LSU_HELD);
    assign lsu_b_error = txn_done && dmem_error;           // Only in completing cycle

    // A misaligned request never completes, not even from the held state
    a_no_ready_on_misalign : assert property (
        @(posedge g_clk) disable iff (!g_resetn)
        !(lsu_ready && lsu_a_error)
    );

    // Ready cannot come while the memory still stalls
    a_no_ready_in_stall : assert property (
        @(posedge g_clk) disable iff (!g_resetn)
        !(lsu_ready && dmem_stall)
    );

endmodule

// ==== logic/lsu_store_align.sv ====
/*
 * Store data aligner.
 * Moves the store byte or halfword onto its byte lanes and builds
 * the matching write strobes.
 */

`timescale 1ns/1ps

module lsu_store_align (
    input  logic           lsu_byte,    // Byte store
    input  logic           lsu_half,    // Halfword store
    input  lsu_pkg::boff_t lsu_boff,    // Byte offset in the word
    input  lsu_pkg::word_t lsu_wdata,   // Store data, right aligned
    output lsu_pkg::word_t dmem_wdata,  // Store data on its lanes
    output lsu_pkg::strb_t dmem_strb    // Byte lane strobes
);

    lsu_pkg::word_t lane_data;          // Data copied onto every lane

    // Lane strobes
    // ------------------------------

    always_comb begin
        if (lsu_byte) begin
            case (lsu_boff)
                2'b00:   dmem_strb = 4'b0001;
                2'b01:   dmem_strb = 4'b0010;
                2'b10:   dmem_strb = 4'b0100;
                default: dmem_strb = 4'b1000;
            endcase
        end else if (lsu_half) begin
            dmem_strb = lsu_boff[1] ? 4'b1100 : 4'b0011;    // Upper or lower half
        end else begin
            dmem_strb = 4'b1111;                            // Full word
        end
    end

    // Lane data
    // ------------------------------

    always_comb begin
        if (lsu_byte) begin
            lane_data = {4{lsu_wdata[7:0]}};
        end else if (lsu_half) begin
            lane_data = {2{lsu_wdata[15:0]}};
        end else begin
            lane_data = lsu_wdata;
        end
    end

    // Unstrobed lanes are driven as zero
    always_comb begin
        for (int i = 0; i < 4; i++) begin
            dmem_wdata[8*i +: 8] = lane_data[8*i +: 8] & {8{dmem_strb[i]}};
        end
    end

endmodule

// ==== logic/lsu_load_align.sv ====
/*
 * Load data aligner.
 * Picks the addressed byte or halfword out of the read word and
 * sign or zero extends it to a full word.
 */

`timescale 1ns/1ps

module lsu_load_align (
    input  logic           lsu_byte,    // Byte load
    input  logic           lsu_half,    // Halfword load
    input  logic           lsu_signed,  // Sign extend the result
    input  lsu_pkg::boff_t lsu_boff,    // Byte offset in the word
    input  lsu_pkg::word_t dmem_rdata,  // Word from memory
    output lsu_pkg::word_t lsu_rdata    // Extended load result
);

    logic [7:0]  pick_b;                // Addressed byte
    logic [15:0] pick_h;                // Addressed halfword
    logic        ext_b;                 // Fill bit for a byte
    logic        ext_h;                 // Fill bit for a halfword

    // Lane select
    // ------------------------------

    always_comb begin
        case (lsu_boff)
            2'b00:   pick_b = dmem_rdata[7:0];
            2'b01:   pick_b = dmem_rdata[15:8];
            2'b10:   pick_b = dmem_rdata[23:16];
            default: pick_b = dmem_rdata[31:24];
        endcase
    end

    // Only offsets 0 and 2 are legal for a halfword
    assign pick_h = lsu_boff[1] ? dmem_rdata[31:16] : dmem_rdata[15:0];

    // Extension
    // ------------------------------

    assign ext_b = lsu_signed && pick_b[7];
    assign ext_h = lsu_signed && pick_h[15];

    always_comb begin
        if (lsu_byte) begin
            lsu_rdata = {{24{ext_b}}, pick_b};
        end else if (lsu_half) begin
            lsu_rdata = {{16{ext_h}}, pick_h};
        end else begin
            lsu_rdata = dmem_rdata;                         // Word as read
        end
    end

endmodule

// ==== logic/dmem_sram.sv ====
/*
 * Data memory model with byte strobes.
 * Inserts 0 to 3 pseudo random wait states per access and answers
 * addresses past the end with a bus error.
 */

`timescale 1ns/1ps

module dmem_sram (
    input  logic           g_clk,       // Global clock
    input  logic           g_resetn,    // Synchronous reset, active low
    input  logic           dmem_cen,    // Chip enable
    input  logic           dmem_wen,    // Write enable
    input  lsu_pkg::addr_t dmem_addr,   // Word aligned byte address
    input  lsu_pkg::word_t dmem_wdata,  // Write data on lanes
    input  lsu_pkg::strb_t dmem_strb,   // Byte lane strobes
    output lsu_pkg::word_t dmem_rdata,  // Read data
    output logic           dmem_stall,  // Access not done
    output logic           dmem_error   // Bus error on completion
);

    lsu_pkg::word_t mem [lsu_pkg::DMEM_WORDS];

    lsu_pkg::mem_state_t mem_state;
    lsu_pkg::mem_state_t n_mem_state;

    logic [7:0] lfsr;                   // Wait state source
    logic       lfsr_fb;
    logic [1:0] draw;                   // Wait count for a new access
    logic [1:0] wait_cnt;               // Remaining wait states
    logic [1:0] n_wait_cnt;

    logic [$clog2(lsu_pkg::DMEM_WORDS)-1:0] word_idx;
    logic out_of_range;
    logic txn_done;

    // Address decode
    // ------------------------------

    assign word_idx     = dmem_addr[$clog2(lsu_pkg::DMEM_WORDS)+1:2];
    assign out_of_range = (dmem_addr >= lsu_pkg::DMEM_ERR_BASE);

    assign txn_done   = dmem_cen && !dmem_stall;
    assign dmem_error = txn_done && out_of_range;
    assign dmem_rdata = out_of_range ? '0 : mem[word_idx];  // Async read

    // Wait state generation
    // ------------------------------

    assign lfsr_fb = lfsr[7] ^ lfsr[5] ^ lfsr[4] ^ lfsr[3];
    assign draw    = lfsr[1:0];

    always_comb begin
        n_mem_state = mem_state;
        n_wait_cnt  = wait_cnt;
        dmem_stall  = 1'b0;
        case (mem_state)
            lsu_pkg::MEM_IDLE: begin
                if (dmem_cen && (draw != 2'd0)) begin
                    dmem_stall  = 1'b1;
                    n_mem_state = lsu_pkg::MEM_WAIT;
                    n_wait_cnt  = draw - 2'd1;
                end
            end
            lsu_pkg::MEM_WAIT: begin
                if (!dmem_cen || (wait_cnt == 2'd0)) begin
                    n_mem_state = lsu_pkg::MEM_IDLE;        // Done or abandoned
                end else begin
                    dmem_stall = 1'b1;
                    n_wait_cnt = wait_cnt - 2'd1;
                end
            end
            default: n_mem_state = lsu_pkg::MEM_IDLE;
        endcase
    end

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            mem_state <= lsu_pkg::MEM_IDLE;
            wait_cnt  <= 2'd0;
            lfsr      <= 8'hA5;                             // Any nonzero seed
        end else begin
            mem_state <= n_mem_state;
            wait_cnt  <= n_wait_cnt;
            lfsr      <= {lfsr[6:0], lfsr_fb};
        end
    end

    // Storage
    // ------------------------------

    always_ff @(posedge g_clk) begin
        if (txn_done && dmem_wen && !out_of_range) begin
            for (int i = 0; i < 4; i++) begin
                if (dmem_strb[i]) begin
                    mem[word_idx][8*i +: 8] <= dmem_wdata[8*i +: 8];
                end
            end
        end
    end

    // The LSU always sends at least one lane with a write
    a_write_has_strobe : assert property (
        @(posedge g_clk) disable iff (!g_resetn)
        (txn_done && dmem_wen) |-> (dmem_strb != '0)
    );

endmodule

// ==== logic/lsu_top.sv ====
/*
 * Load/store subsystem top level.
 * Connects LSU control, store and load aligners and the data memory.
 */

`timescale 1ns/1ps

module lsu_top (
    input  logic           g_clk,       // Global clock
    input  logic           g_resetn,    // Synchronous reset, active low
    input  logic           lsu_valid,   // Request present
    input  lsu_pkg::addr_t lsu_addr,    // Byte address
    input  lsu_pkg::word_t lsu_wdata,   // Store data
    input  logic           lsu_load,    // Load request
    input  logic           lsu_store,   // Store request
    input  logic           lsu_byte,    // Byte width
    input  logic           lsu_half,    // Halfword width
    input  logic           lsu_word,    // Word width
    input  logic           lsu_signed,  // Sign extend load data
    input  logic           pipe_prog,   // Pipeline takes the result
    output lsu_pkg::word_t lsu_rdata,   // Load result
    output logic           lsu_a_error, // Misaligned address
    output logic           lsu_b_error, // Bus error
    output logic           lsu_ready    // Access complete
);

    lsu_pkg::boff_t lsu_boff;

    logic           dmem_cen;
    logic           dmem_wen;
    lsu_pkg::addr_t dmem_addr;
    lsu_pkg::word_t dmem_wdata;
    lsu_pkg::strb_t dmem_strb;
    lsu_pkg::word_t dmem_rdata;
    logic           dmem_stall;
    logic           dmem_error;

    assign lsu_boff  = lsu_addr[1:0];
    assign dmem_addr = {lsu_addr[31:2], 2'b00};             // Word aligned

    // Blocks
    // ------------------------------

    lsu_ctrl ctrl0 (
        .g_clk       (g_clk),
        .g_resetn    (g_resetn),
        .lsu_valid   (lsu_valid),
        .lsu_store   (lsu_store),
        .lsu_byte    (lsu_byte),
        .lsu_half    (lsu_half),
        .lsu_word    (lsu_word),
        .pipe_prog   (pipe_prog),
        .lsu_boff    (lsu_boff),
        .dmem_stall  (dmem_stall),
        .dmem_error  (dmem_error),
        .lsu_ready   (lsu_ready),
        .lsu_a_error (lsu_a_error),
        .lsu_b_error (lsu_b_error),
        .dmem_cen    (dmem_cen),
        .dmem_wen    (dmem_wen)
    );

    lsu_store_align st_align0 (
        .lsu_byte   (lsu_byte),
        .lsu_half   (lsu_half),
        .lsu_boff   (lsu_boff),
        .lsu_wdata  (lsu_wdata),
        .dmem_wdata (dmem_wdata),
        .dmem_strb  (dmem_strb)
    );

    lsu_load_align ld_align0 (
        .lsu_byte   (lsu_byte),
        .lsu_half   (lsu_half),
        .lsu_signed (lsu_signed),
        .lsu_boff   (lsu_boff),
        .dmem_rdata (dmem_rdata),
        .lsu_rdata  (lsu_rdata)
    );

    dmem_sram mem0 (
        .g_clk      (g_clk),
        .g_resetn   (g_resetn),
        .dmem_cen   (dmem_cen),
        .dmem_wen   (dmem_wen),
        .dmem_addr  (dmem_addr),
        .dmem_wdata (dmem_wdata),
        .dmem_strb  (dmem_strb),
        .dmem_rdata (dmem_rdata),
        .dmem_stall (dmem_stall),
        .dmem_error (dmem_error)
    );

    // Execute stage sends exactly one kind and one width per request
    a_request_well_formed : assert property (
        @(posedge g_clk) disable iff (!g_resetn)
        lsu_valid |-> ((lsu_load ^ lsu_store) && $onehot({lsu_byte, lsu_half, lsu_word}))
    );

endmodule

// ==== sim/tb_lsu.sv ====
/*
 * Load/store subsystem testbench.
 * Preloads the data memory, then runs random loads and stores against
 * a shadow memory model with a watchdog on the whole run.
 */

`timescale 1ns/1ps

module tb_lsu;

    localparam int N_REQ        = 600;
    localparam int RESET_CYCLES = 8;
    localparam int CYCLE_NS     = 4;
    localparam int WATCHDOG_NS  =
        (N_REQ + lsu_pkg::DMEM_WORDS + RESET_CYCLES) * 12 * CYCLE_NS;

    localparam logic [1:0] W_BYTE = 2'd0;
    localparam logic [1:0] W_HALF = 2'd1;
    localparam logic [1:0] W_WORD = 2'd2;

    logic           g_clk;
    logic           g_resetn;
    logic           lsu_valid;
    lsu_pkg::addr_t lsu_addr;
    lsu_pkg::word_t lsu_wdata;
    logic           lsu_load;
    logic           lsu_store;
    logic           lsu_byte;
    logic           lsu_half;
    logic           lsu_word;
    logic           lsu_signed;
    logic           pipe_prog;
    lsu_pkg::word_t lsu_rdata;
    logic           lsu_a_error;
    logic           lsu_b_error;
    logic           lsu_ready;

    lsu_pkg::word_t shadow [lsu_pkg::DMEM_WORDS];  // Expected memory contents
    logic [31:0]    rng_state;

    lsu_top dut0 (
        .g_clk       (g_clk),
        .g_resetn    (g_resetn),
        .lsu_valid   (lsu_valid),
        .lsu_addr    (lsu_addr),
        .lsu_wdata   (lsu_wdata),
        .lsu_load    (lsu_load),
        .lsu_store   (lsu_store),
        .lsu_byte    (lsu_byte),
        .lsu_half    (lsu_half),
        .lsu_word    (lsu_word),
        .lsu_signed  (lsu_signed),
        .pipe_prog   (pipe_prog),
        .lsu_rdata   (lsu_rdata),
        .lsu_a_error (lsu_a_error),
        .lsu_b_error (lsu_b_error),
        .lsu_ready   (lsu_ready)
    );

    always #(CYCLE_NS / 2) g_clk = ~g_clk;

    // Helpers
    // ------------------------------

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] next_random();
        rng_state = xorshift(rng_state);
        return rng_state;
    endfunction

    // Preload pattern, mixes every address bit
    function automatic lsu_pkg::word_t fill_word(input lsu_pkg::addr_t a);
        return (a * 32'h9E37_79B1) ^ 32'h5A5A_0000;
    endfunction

    function automatic lsu_pkg::word_t expect_load(input lsu_pkg::word_t w,
            input logic [1:0] wsel, input logic sgn, input logic [1:0] off);
        lsu_pkg::word_t sh;
        sh = w >> {off, 3'b000};                    // Addressed lane to bit 0
        if (wsel == W_BYTE) begin
            return {{24{sgn & sh[7]}}, sh[7:0]};
        end else if (wsel == W_HALF) begin
            return {{16{sgn & sh[15]}}, sh[15:0]};
        end else begin
            return w;
        end
    endfunction

    task automatic model_store(input int idx, input logic [1:0] off,
            input logic [1:0] wsel, input lsu_pkg::word_t wdata);
        case (wsel)
            W_BYTE:  shadow[idx][{off, 3'b000} +: 8]  = wdata[7:0];
            W_HALF:  shadow[idx][{off, 3'b000} +: 16] = wdata[15:0];
            default: shadow[idx] = wdata;
        endcase
    endtask

    task automatic fail_run(input string why);
        $display("SIMULATION FAILED");
        $fatal(1, "%s", why);
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        assert (act === exp) else begin
            $display("ERR %0t %s expected %b actual %b", $time, name, exp, act);
            fail_run("output bit mismatch");
        end
    endtask

    task automatic check_word(input string name, input lsu_pkg::word_t exp,
            input lsu_pkg::word_t act);
        assert (act === exp) else begin
            $display("ERR %0t %s expected %h actual %h", $time, name, exp, act);
            fail_run("output word mismatch");
        end
    endtask

    // One request from first drive to pipe_prog
    // ------------------------------

    task automatic run_request(input logic st, input logic [1:0] wsel, input logic sgn,
            input lsu_pkg::addr_t addr, input lsu_pkg::word_t wdata, input int delay);
        logic [1:0]     off;
        logic           misal;
        logic           oor;
        int             idx;
        int             i;
        lsu_pkg::word_t exp_data;

        off      = addr[1:0];
        misal    = ((wsel == W_HALF) && off[0]) || ((wsel == W_WORD) && (off != 2'b00));
        oor      = (addr >= lsu_pkg::DMEM_ERR_BASE);
        idx      = oor ? 0 : int'(addr >> 2);
        exp_data = oor ? '0 : expect_load(shadow[idx], wsel, sgn, off);   // Past end reads 0

        @(negedge g_clk);
        lsu_valid  = 1'b1;
        lsu_addr   = addr;
        lsu_wdata  = wdata;
        lsu_load   = !st;
        lsu_store  = st;
        lsu_byte   = (wsel == W_BYTE);
        lsu_half   = (wsel == W_HALF);
        lsu_word   = (wsel == W_WORD);
        lsu_signed = sgn;
        pipe_prog  = (delay == 0);                  // Zero delay keeps the pipe moving

        if (misal) begin
            for (i = 0; i <= delay; i++) begin
                if (i > 0) begin
                    @(negedge g_clk);
                    pipe_prog = (i == delay);
                end
                #1;
                check_bit("lsu_a_error", 1'b1, lsu_a_error);
                check_bit("lsu_ready", 1'b0, lsu_ready);
            end
        end else begin
            #1;
            check_bit("lsu_a_error", 1'b0, lsu_a_error);
            while (!lsu_ready) begin                // Memory wait states
                @(negedge g_clk);
                #1;
                check_bit("lsu_a_error", 1'b0, lsu_a_error);
            end
            if (!st) begin
                check_word("lsu_rdata", exp_data, lsu_rdata);
            end
            check_bit("lsu_b_error", oor, lsu_b_error);
            for (i = 1; i <= delay; i++) begin      // Held until pipe_prog
                @(negedge g_clk);
                pipe_prog = (i == delay);
                #1;
                check_bit("lsu_ready", 1'b1, lsu_ready);
                check_bit("lsu_b_error", 1'b0, lsu_b_error);
            end
            if (st && !oor) begin
                model_store(idx, off, wsel, wdata);
            end
        end
    endtask

    // Main sequence
    // ------------------------------

    initial begin
        lsu_pkg::addr_t base;
        lsu_pkg::addr_t addr;
        logic [31:0]    r_a;
        logic [31:0]    r_c;
        logic [31:0]    wd;
        logic [1:0]     wsel;
        logic [1:0]     off;
        int             n;

        g_clk      = 1'b0;
        g_resetn   = 1'b0;
        lsu_valid  = 1'b0;
        lsu_addr   = '0;
        lsu_wdata  = '0;
        lsu_load   = 1'b0;
        lsu_store  = 1'b0;
        lsu_byte   = 1'b0;
        lsu_half   = 1'b0;
        lsu_word   = 1'b0;
        lsu_signed = 1'b0;
        pipe_prog  = 1'b0;
        rng_state  = 32'ha144;

        repeat (RESET_CYCLES) @(posedge g_clk);
        @(negedge g_clk);
        g_resetn = 1'b1;
        #1;
        check_bit("lsu_ready", 1'b0, lsu_ready);
        check_bit("lsu_b_error", 1'b0, lsu_b_error);

        // Give every word a known value
        for (n = 0; n < lsu_pkg::DMEM_WORDS; n++) begin
            addr = lsu_pkg::addr_t'(n * 4);
            run_request(1'b1, W_WORD, 1'b0, addr, fill_word(addr), 0);
        end

        for (n = 0; n < N_REQ; n++) begin
            r_a  = next_random();
            r_c  = next_random();
            wd   = next_random();
            wsel = (r_c[9:8] == 2'd3) ? W_WORD : r_c[9:8];
            case (r_a[2:0])
                3'd0:    base = lsu_pkg::DMEM_ERR_BASE + {20'h0, r_a[13:4], 2'b00};
                3'd1:    base = {20'h0, r_a[13:4], 2'b00};          // Anywhere in memory
                default: base = 32'h100 + {26'h0, r_a[7:4], 2'b00}; // Busy window
            endcase
            if (r_c[2:0] == 3'd0) begin
                off = r_c[5:4];                     // Free offset, may misalign
            end else if (wsel == W_BYTE) begin
                off = r_c[5:4];
            end else if (wsel == W_HALF) begin
                off = {r_c[5], 1'b0};
            end else begin
                off = 2'b00;
            end
            addr = base | {30'h0, off};
            run_request(r_c[10], wsel, r_c[11], addr, wd, int'(r_c[13:12]));
        end

        @(negedge g_clk);
        lsu_valid = 1'b0;
        pipe_prog = 1'b0;
        #1;
        check_bit("lsu_ready", 1'b0, lsu_ready);

        $display("SIMULATION PASSED");
        $finish;
    end

    // Watchdog
    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: requests did not finish within %0d ns", WATCHDOG_NS);
        fail_run("watchdog expired");
    end

endmodule

// ==== tb.f ====
logic/lsu_pkg.sv
logic/lsu_ctrl.sv
logic/lsu_store_align.sv
logic/lsu_load_align.sv
logic/dmem_sram.sv
logic/lsu_top.sv
sim/tb_lsu.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the LSU testbench with Verilator, run it and check the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log
rm -f "$LOG"

verilator --binary --timing --assert -j 0 \
    -f tb.f --top-module tb_lsu -Mdir obj_dir \
    && ./obj_dir/Vtb_lsu > "$LOG" 2>&1 \
    || echo "Build or simulation returned an error"

cat "$LOG" 2>/dev/null

grep -q "SIMULATION PASSED" "$LOG" \
    && { echo "Result: pass"; exit 0; } \
    || { echo "Result: fail"; exit 1; }
